//--- design/ram_ctrl_pkg.sv
// shared widths and encodings; the SRAM is two 16-bit chips side by side, 18 address bits
package ram_ctrl_pkg;

   // --------------------
   // requester widths
   // --------------------
   typedef logic [13:0] mcr_addr_t;
   typedef logic [48:0] mcr_word_t;
   typedef logic [21:0] sdram_addr_t;
   typedef logic [14:0] vga_addr_t;
   typedef logic [31:0] word_t;

   // --------------------
   // sram pin widths
   // --------------------
   typedef logic [17:0] sram_addr_t;
   typedef logic [15:0] sram_half_t;

   // access states, one per sram access kind
   // microcode words take a hi and a lo access
   typedef enum logic [2:0] {
      st_idle,
      st_mcr_rd_hi,
      st_mcr_rd_lo,
      st_mcr_wr_hi,
      st_mcr_wr_lo,
      st_vga_rd,
      st_sdram_rd,
      st_sdram_wr
   } access_t;

   // main-memory bits that land in the sram
   localparam int SDRAM_WINDOW_BITS = 17;

   // partition map on sram_a[17:15]
   //   0xx  sdram
   //   10x  microcode
   //   11x  video
   localparam logic [2:0] MCR_PREFIX = 3'b100;
   localparam logic [2:0] VGA_PREFIX = 3'b110;

   // fixed priority, lowest index wins
   localparam int NUM_REQ      = 5;
   localparam int PRI_MCR_RD   = 0;
   localparam int PRI_MCR_WR   = 1;
   localparam int PRI_VGA_RD   = 2;
   localparam int PRI_SDRAM_RD = 3;
   localparam int PRI_SDRAM_WR = 4;

endpackage

//--- design/port_arbiter.sv
// requesters must hold address and write data stable until their flag rises
`timescale 1ns/1ps

module port_arbiter
(
   input  logic                      clk,
   input  logic                      reset,
   input  logic                      mcr_read,
   input  logic                      mcr_write,
   input  ram_ctrl_pkg::mcr_addr_t   mcr_addr,
   input  ram_ctrl_pkg::mcr_word_t   mcr_wdata,
   input  logic                      vga_read,
   input  ram_ctrl_pkg::vga_addr_t   vga_addr,
   input  logic                      sdram_read,
   input  logic                      sdram_write,
   input  ram_ctrl_pkg::sdram_addr_t sdram_addr,
   input  ram_ctrl_pkg::word_t       sdram_wdata,
   input  logic                      cycle_idle,
   input  logic                      cycle_end,
   input  logic                      mcr_ready,
   input  logic                      mcr_done,
   input  logic                      vga_ready,
   input  logic                      sdram_ready,
   input  logic                      sdram_done,
   output ram_ctrl_pkg::access_t     access,
   output ram_ctrl_pkg::sram_addr_t  req_a,
   output ram_ctrl_pkg::sram_half_t  req_wdata1,
   output ram_ctrl_pkg::sram_half_t  req_wdata2,
   output logic                      req_oe_n,
   output logic                      req_we_n
);

   logic [ram_ctrl_pkg::NUM_REQ-1:0] pending;
   ram_ctrl_pkg::access_t            idle_next;
   ram_ctrl_pkg::mcr_addr_t          mcr_addr_q;
   logic                             mcr_half;

   // --------------------
   // request selection
   // --------------------

   // a request counts only while its flag is still low
   always_comb
   begin
      pending = '0;
      pending[ram_ctrl_pkg::PRI_MCR_RD]   = mcr_read && !mcr_ready;
      pending[ram_ctrl_pkg::PRI_MCR_WR]   = mcr_write && !mcr_done;
      pending[ram_ctrl_pkg::PRI_VGA_RD]   = vga_read && !vga_ready;
      pending[ram_ctrl_pkg::PRI_SDRAM_RD] = sdram_read && !sdram_ready;
      pending[ram_ctrl_pkg::PRI_SDRAM_WR] = sdram_write && !sdram_done;

      if (pending[ram_ctrl_pkg::PRI_MCR_RD])
         idle_next = ram_ctrl_pkg::st_mcr_rd_hi;
      else if (pending[ram_ctrl_pkg::PRI_MCR_WR])
         idle_next = ram_ctrl_pkg::st_mcr_wr_hi;
      else if (pending[ram_ctrl_pkg::PRI_VGA_RD])
         idle_next = ram_ctrl_pkg::st_vga_rd;
      else if (pending[ram_ctrl_pkg::PRI_SDRAM_RD])
         idle_next = ram_ctrl_pkg::st_sdram_rd;
      else if (pending[ram_ctrl_pkg::PRI_SDRAM_WR])
         idle_next = ram_ctrl_pkg::st_sdram_wr;
      else
         idle_next = ram_ctrl_pkg::st_idle;
   end

   // busy states advance only when the cycle stage finishes
   always_ff @(posedge clk)
   begin
      if (reset)
         access <= ram_ctrl_pkg::st_idle;
      else if (access == ram_ctrl_pkg::st_idle)
      begin
         if (cycle_idle)
            access <= idle_next;
      end
      else if (cycle_end)
      begin
         case (access)
            ram_ctrl_pkg::st_mcr_rd_hi: access <= ram_ctrl_pkg::st_mcr_rd_lo;
            ram_ctrl_pkg::st_mcr_wr_hi: access <= ram_ctrl_pkg::st_mcr_wr_lo;
            default:                    access <= ram_ctrl_pkg::st_idle;
         endcase
      end
   end

   // address held across both halves of a microcode word
   always_ff @(posedge clk)
   begin
      if (access == ram_ctrl_pkg::st_idle && cycle_idle &&
          (idle_next == ram_ctrl_pkg::st_mcr_rd_hi ||
           idle_next == ram_ctrl_pkg::st_mcr_wr_hi))
         mcr_addr_q <= mcr_addr;
   end

   // --------------------
   // sram request
   // --------------------

   // half bit 0 selects the hi word
   assign mcr_half = access == ram_ctrl_pkg::st_mcr_rd_lo ||
                     access == ram_ctrl_pkg::st_mcr_wr_lo;

   always_comb
   begin
      req_a      = '0;
      req_wdata1 = '0;
      req_wdata2 = '0;
      req_oe_n   = 1'b1;
      req_we_n   = 1'b1;
      case (access)
         ram_ctrl_pkg::st_mcr_rd_hi, ram_ctrl_pkg::st_mcr_rd_lo:
         begin
            req_a    = {ram_ctrl_pkg::MCR_PREFIX, mcr_addr_q, mcr_half};
            req_oe_n = 1'b0;
         end
         ram_ctrl_pkg::st_mcr_wr_hi:
         begin
            req_a      = {ram_ctrl_pkg::MCR_PREFIX, mcr_addr_q, mcr_half};
            req_wdata1 = {15'b0, mcr_wdata[48]};
            req_wdata2 = mcr_wdata[47:32];
            req_we_n   = 1'b0;
         end
         ram_ctrl_pkg::st_mcr_wr_lo:
         begin
            req_a      = {ram_ctrl_pkg::MCR_PREFIX, mcr_addr_q, mcr_half};
            req_wdata1 = mcr_wdata[31:16];
            req_wdata2 = mcr_wdata[15:0];
            req_we_n   = 1'b0;
         end
         ram_ctrl_pkg::st_vga_rd:
         begin
            req_a    = {ram_ctrl_pkg::VGA_PREFIX, vga_addr};
            req_oe_n = 1'b0;
         end
         ram_ctrl_pkg::st_sdram_rd:
         begin
            req_a    = {1'b0, sdram_addr[ram_ctrl_pkg::SDRAM_WINDOW_BITS-1:0]};
            req_oe_n = 1'b0;
         end
         ram_ctrl_pkg::st_sdram_wr:
         begin
            req_a      = {1'b0, sdram_addr[ram_ctrl_pkg::SDRAM_WINDOW_BITS-1:0]};
            req_wdata1 = sdram_wdata[31:16];
            req_wdata2 = sdram_wdata[15:0];
            req_we_n   = 1'b0;
         end
         default:
         begin
            req_a = '0;
         end
      endcase
   end

endmodule

//--- design/sram_cycle.sv
// every access takes exactly three clocks; writes land on the rising edge of sram_we_n
`timescale 1ns/1ps

module sram_cycle
(
   input  logic                     clk,
   input  logic                     reset,
   input  ram_ctrl_pkg::access_t    access,
   input  ram_ctrl_pkg::sram_addr_t req_a,
   input  ram_ctrl_pkg::sram_half_t req_wdata1,
   input  ram_ctrl_pkg::sram_half_t req_wdata2,
   input  logic                     req_oe_n,
   input  logic                     req_we_n,
   input  ram_ctrl_pkg::sram_half_t sram1_rdata,
   input  ram_ctrl_pkg::sram_half_t sram2_rdata,
   output logic                     cycle_idle,
   output logic                     cycle_end,
   output ram_ctrl_pkg::access_t    done_access,
   output ram_ctrl_pkg::sram_half_t rd_half1,
   output ram_ctrl_pkg::sram_half_t rd_half2,
   output ram_ctrl_pkg::sram_addr_t sram_a,
   output logic                     sram_oe_n,
   output logic                     sram_we_n,
   output logic                     sram_ce_n,
   output ram_ctrl_pkg::sram_half_t sram1_wdata,
   output ram_ctrl_pkg::sram_half_t sram2_wdata
);

   typedef enum logic [1:0] {
      step_free,
      step_wait,
      step_end
   } step_t;

   step_t                 step;
   ram_ctrl_pkg::access_t busy_access;
   logic                  start;

   assign start     = step == step_free && access != ram_ctrl_pkg::st_idle;
   assign cycle_end = step == step_end;

   // still busy while the finished access has not reached the flags
   assign cycle_idle = step == step_free && done_access == ram_ctrl_pkg::st_idle;

   // --------------------
   // sequencer
   // --------------------
   always_ff @(posedge clk)
   begin
      if (reset)
      begin
         step        <= step_free;
         busy_access <= ram_ctrl_pkg::st_idle;
         done_access <= ram_ctrl_pkg::st_idle;
         sram_oe_n   <= 1'b1;
         sram_we_n   <= 1'b1;
         sram_ce_n   <= 1'b1;
      end
      else
      begin
         done_access <= ram_ctrl_pkg::st_idle;
         case (step)
            step_free:
            begin
               if (start)
               begin
                  step        <= step_wait;
                  busy_access <= access;
                  sram_oe_n   <= req_oe_n;
                  sram_we_n   <= req_we_n;
                  sram_ce_n   <= 1'b0;
               end
            end
            step_wait:
            begin
               step <= step_end;
            end
            default:
            begin
               // release all strobes; the we_n edge commits a write
               step        <= step_free;
               done_access <= busy_access;
               busy_access <= ram_ctrl_pkg::st_idle;
               sram_oe_n   <= 1'b1;
               sram_we_n   <= 1'b1;
               sram_ce_n   <= 1'b1;
            end
         endcase
      end
   end

   // address and write data stay put until the next start
   always_ff @(posedge clk)
   begin
      if (start)
      begin
         sram_a      <= req_a;
         sram1_wdata <= req_wdata1;
         sram2_wdata <= req_wdata2;
      end
   end

   // read halves sampled with oe_n still low
   always_ff @(posedge clk)
   begin
      if (cycle_end)
      begin
         rd_half1 <= sram1_rdata;
         rd_half2 <= sram2_rdata;
      end
   end

endmodule

//--- design/port_response.sv
// flags are levels; each clears one clock after its requester drops the request
`timescale 1ns/1ps

module port_response
(
   input  logic                      clk,
   input  logic                      reset,
   input  ram_ctrl_pkg::access_t     done_access,
   input  ram_ctrl_pkg::sram_half_t  rd_half1,
   input  ram_ctrl_pkg::sram_half_t  rd_half2,
   input  logic                      mcr_read,
   input  logic                      mcr_write,
   input  logic                      vga_read,
   input  logic                      sdram_read,
   input  logic                      sdram_write,
   input  ram_ctrl_pkg::sdram_addr_t sdram_addr,
   output ram_ctrl_pkg::mcr_word_t   mcr_rdata,
   output logic                      mcr_ready,
   output logic                      mcr_done,
   output ram_ctrl_pkg::word_t       vga_rdata,
   output logic                      vga_ready,
   output ram_ctrl_pkg::word_t       sdram_rdata,
   output logic                      sdram_ready,
   output logic                      sdram_done
);

   ram_ctrl_pkg::word_t rd_word;
   logic                in_window;

   // sram1 is the upper half
   assign rd_word = {rd_half1, rd_half2};

   // sdram addresses above the sram window read as all ones
   assign in_window =
      sdram_addr[$bits(ram_ctrl_pkg::sdram_addr_t)-1:ram_ctrl_pkg::SDRAM_WINDOW_BITS] == '0;

   // --------------------
   // microcode
   // --------------------
   always_ff @(posedge clk)
   begin
      if (reset)
      begin
         mcr_rdata <= '0;
         mcr_ready <= 1'b0;
         mcr_done  <= 1'b0;
      end
      else
      begin
         // hi word carries bit 48 in sram1 bit 0
         if (done_access == ram_ctrl_pkg::st_mcr_rd_hi)
            mcr_rdata[48:32] <= {rd_half1[0], rd_half2};
         if (done_access == ram_ctrl_pkg::st_mcr_rd_lo)
            mcr_rdata[31:0] <= rd_word;

         if (done_access == ram_ctrl_pkg::st_mcr_rd_lo)
            mcr_ready <= 1'b1;
         else if (!mcr_read)
            mcr_ready <= 1'b0;

         if (done_access == ram_ctrl_pkg::st_mcr_wr_lo)
            mcr_done <= 1'b1;
         else if (!mcr_write)
            mcr_done <= 1'b0;
      end
   end

   // --------------------
   // video
   // --------------------
   always_ff @(posedge clk)
   begin
      if (reset)
      begin
         vga_rdata <= '0;
         vga_ready <= 1'b0;
      end
      else if (done_access == ram_ctrl_pkg::st_vga_rd)
      begin
         vga_rdata <= rd_word;
         vga_ready <= 1'b1;
      end
      else if (!vga_read)
         vga_ready <= 1'b0;
   end

   // --------------------
   // main memory
   // --------------------
   always_ff @(posedge clk)
   begin
      if (reset)
      begin
         sdram_rdata <= '0;
         sdram_ready <= 1'b0;
         sdram_done  <= 1'b0;
      end
      else
      begin
         if (done_access == ram_ctrl_pkg::st_sdram_rd)
         begin
            sdram_rdata <= in_window ? rd_word : '1;
            sdram_ready <= 1'b1;
         end
         else if (!sdram_read)
            sdram_ready <= 1'b0;

         if (done_access == ram_ctrl_pkg::st_sdram_wr)
            sdram_done <= 1'b1;
         else if (!sdram_write)
            sdram_done <= 1'b0;
      end
   end

endmodule

//--- design/pipe_ram_controller.sv
// single clock; one shared chip enable drives both chips and the byte lanes stay enabled
`timescale 1ns/1ps

module pipe_ram_controller
(
   input  logic                      clk,
   input  logic                      reset,
   input  logic                      mcr_read,
   input  logic                      mcr_write,
   input  ram_ctrl_pkg::mcr_addr_t   mcr_addr,
   input  ram_ctrl_pkg::mcr_word_t   mcr_wdata,
   input  logic                      sdram_read,
   input  logic                      sdram_write,
   input  ram_ctrl_pkg::sdram_addr_t sdram_addr,
   input  ram_ctrl_pkg::word_t       sdram_wdata,
   input  logic                      vga_read,
   input  ram_ctrl_pkg::vga_addr_t   vga_addr,
   output ram_ctrl_pkg::mcr_word_t   mcr_rdata,
   output logic                      mcr_ready,
   output logic                      mcr_done,
   output ram_ctrl_pkg::word_t       sdram_rdata,
   output logic                      sdram_ready,
   output logic                      sdram_done,
   output ram_ctrl_pkg::word_t       vga_rdata,
   output logic                      vga_ready,
   output ram_ctrl_pkg::sram_addr_t  sram_a,
   output logic                      sram_oe_n,
   output logic                      sram_we_n,
   output logic                      sram_ce_n,
   output ram_ctrl_pkg::sram_half_t  sram1_wdata,
   output ram_ctrl_pkg::sram_half_t  sram2_wdata,
   input  ram_ctrl_pkg::sram_half_t  sram1_rdata,
   input  ram_ctrl_pkg::sram_half_t  sram2_rdata
);

   // arbiter to cycle stage
   ram_ctrl_pkg::access_t    access;
   ram_ctrl_pkg::sram_addr_t req_a;
   ram_ctrl_pkg::sram_half_t req_wdata1;
   ram_ctrl_pkg::sram_half_t req_wdata2;
   logic                     req_oe_n;
   logic                     req_we_n;
   logic                     cycle_idle;
   logic                     cycle_end;

   // cycle stage to response stage
   ram_ctrl_pkg::access_t    done_access;
   ram_ctrl_pkg::sram_half_t rd_half1;
   ram_ctrl_pkg::sram_half_t rd_half2;

   port_arbiter i_port_arbiter
   (
      .clk         (clk),
      .reset       (reset),
      .mcr_read    (mcr_read),
      .mcr_write   (mcr_write),
      .mcr_addr    (mcr_addr),
      .mcr_wdata   (mcr_wdata),
      .vga_read    (vga_read),
      .vga_addr    (vga_addr),
      .sdram_read  (sdram_read),
      .sdram_write (sdram_write),
      .sdram_addr  (sdram_addr),
      .sdram_wdata (sdram_wdata),
      .cycle_idle  (cycle_idle),
      .cycle_end   (cycle_end),
      .mcr_ready   (mcr_ready),
      .mcr_done    (mcr_done),
      .vga_ready   (vga_ready),
      .sdram_ready (sdram_ready),
      .sdram_done  (sdram_done),
      .access      (access),
      .req_a       (req_a),
      .req_wdata1  (req_wdata1),
      .req_wdata2  (req_wdata2),
      .req_oe_n    (req_oe_n),
      .req_we_n    (req_we_n)
   );

   sram_cycle i_sram_cycle
   (
      .clk         (clk),
      .reset       (reset),
      .access      (access),
      .req_a       (req_a),
      .req_wdata1  (req_wdata1),
      .req_wdata2  (req_wdata2),
      .req_oe_n    (req_oe_n),
      .req_we_n    (req_we_n),
      .sram1_rdata (sram1_rdata),
      .sram2_rdata (sram2_rdata),
      .cycle_idle  (cycle_idle),
      .cycle_end   (cycle_end),
      .done_access (done_access),
      .rd_half1    (rd_half1),
      .rd_half2    (rd_half2),
      .sram_a      (sram_a),
      .sram_oe_n   (sram_oe_n),
      .sram_we_n   (sram_we_n),
      .sram_ce_n   (sram_ce_n),
      .sram1_wdata (sram1_wdata),
      .sram2_wdata (sram2_wdata)
   );

   port_response i_port_response
   (
      .clk         (clk),
      .reset       (reset),
      .done_access (done_access),
      .rd_half1    (rd_half1),
      .rd_half2    (rd_half2),
      .mcr_read    (mcr_read),
      .mcr_write   (mcr_write),
      .vga_read    (vga_read),
      .sdram_read  (sdram_read),
      .sdram_write (sdram_write),
      .sdram_addr  (sdram_addr),
      .mcr_rdata   (mcr_rdata),
      .mcr_ready   (mcr_ready),
      .mcr_done    (mcr_done),
      .vga_rdata   (vga_rdata),
      .vga_ready   (vga_ready),
      .sdram_rdata (sdram_rdata),
      .sdram_ready (sdram_ready),
      .sdram_done  (sdram_done)
   );

endmodule

//--- verif/sram_model.sv
// two async 16-bit chips; unwritten words read back their own address, writes land on we_n rising
`timescale 1ns/1ps

module sram_model
(
   input  ram_ctrl_pkg::sram_addr_t sram_a,
   input  logic                     sram_oe_n,
   input  logic                     sram_we_n,
   input  logic                     sram_ce_n,
   input  ram_ctrl_pkg::sram_half_t sram1_wdata,
   input  ram_ctrl_pkg::sram_half_t sram2_wdata,
   output ram_ctrl_pkg::sram_half_t sram1_rdata,
   output ram_ctrl_pkg::sram_half_t sram2_rdata
);

   localparam int DEPTH = 1 << $bits(ram_ctrl_pkg::sram_addr_t);

   ram_ctrl_pkg::sram_half_t mem1 [DEPTH];
   ram_ctrl_pkg::sram_half_t mem2 [DEPTH];
   logic                     write_armed = 1'b0;

   // chip 1 holds the top address bits, chip 2 the low 16
   initial
   begin
      for (int i = 0; i < DEPTH; i++)
      begin
         mem1[i] = 16'(i >> 16);
         mem2[i] = 16'(i);
      end
   end

   // ignores the power-up edge of we_n
   always @(negedge sram_we_n)
      write_armed = 1'b1;

   always @(posedge sram_we_n)
   begin
      if (write_armed)
      begin
         mem1[sram_a] = sram1_wdata;
         mem2[sram_a] = sram2_wdata;
      end
   end

   assign sram1_rdata = (!sram_oe_n && !sram_ce_n) ? mem1[sram_a] : '0;
   assign sram2_rdata = (!sram_oe_n && !sram_ce_n) ? mem2[sram_a] : '0;

endmodule

//--- verif/tb_pipe_ram_controller.sv
// xorshift stimulus, seed 8; every flag wait gives up after 200 cycles
`timescale 1ns/1ps

module tb_pipe_ram_controller;

   localparam int TIMEOUT_CYCLES = 200;
   localparam int NUM_WORDS      = 8;

   logic                      clk;
   logic                      reset;
   logic                      mcr_read;
   logic                      mcr_write;
   ram_ctrl_pkg::mcr_addr_t   mcr_addr;
   ram_ctrl_pkg::mcr_word_t   mcr_wdata;
   logic                      sdram_read;
   logic                      sdram_write;
   ram_ctrl_pkg::sdram_addr_t sdram_addr;
   ram_ctrl_pkg::word_t       sdram_wdata;
   logic                      vga_read;
   ram_ctrl_pkg::vga_addr_t   vga_addr;
   ram_ctrl_pkg::mcr_word_t   mcr_rdata;
   logic                      mcr_ready;
   logic                      mcr_done;
   ram_ctrl_pkg::word_t       sdram_rdata;
   logic                      sdram_ready;
   logic                      sdram_done;
   ram_ctrl_pkg::word_t       vga_rdata;
   logic                      vga_ready;
   ram_ctrl_pkg::sram_addr_t  sram_a;
   logic                      sram_oe_n;
   logic                      sram_we_n;
   logic                      sram_ce_n;
   ram_ctrl_pkg::sram_half_t  sram1_wdata;
   ram_ctrl_pkg::sram_half_t  sram2_wdata;
   ram_ctrl_pkg::sram_half_t  sram1_rdata;
   ram_ctrl_pkg::sram_half_t  sram2_rdata;

   // shadow of the sram, keyed by pin address, sram1 in the upper half
   ram_ctrl_pkg::word_t       shadow [int];
   ram_ctrl_pkg::mcr_addr_t   mcr_used [$];
   ram_ctrl_pkg::sdram_addr_t sdram_used [$];
   logic [31:0]               rng;
   int                        errors;
   int                        tests;
   bit                        timed_out;

   pipe_ram_controller i_dut (.*);

   sram_model i_sram_model (.*);

   always #20 clk = ~clk;

   // --------------------
   // reference model
   // --------------------
   function automatic logic [31:0] next_random();
      rng = rng ^ (rng << 13);
      rng = rng ^ (rng >> 17);
      rng = rng ^ (rng << 5);
      return rng;
   endfunction

   // unwritten words hold their own address
   function automatic ram_ctrl_pkg::word_t shadow_word(input ram_ctrl_pkg::sram_addr_t a);
      if (shadow.exists(int'(a)))
         return shadow[int'(a)];
      return {14'b0, a};
   endfunction

   // hi word at half bit 0 carries bits 48..32
   function automatic ram_ctrl_pkg::mcr_word_t mcr_expected(input ram_ctrl_pkg::mcr_addr_t a);
      ram_ctrl_pkg::word_t hi;
      ram_ctrl_pkg::word_t lo;
      hi = shadow_word({3'b100, a, 1'b0});
      lo = shadow_word({3'b100, a, 1'b1});
      return {hi[16:0], lo};
   endfunction

   function automatic ram_ctrl_pkg::word_t sdram_expected(input ram_ctrl_pkg::sdram_addr_t a);
      if (a[21:17] != 5'b0)
         return '1;
      return shadow_word({1'b0, a[16:0]});
   endfunction

   // --------------------
   // compare tasks
   // --------------------
   task automatic check_mcr(input string name, input ram_ctrl_pkg::mcr_word_t got,
                            input ram_ctrl_pkg::mcr_word_t exp);
      if (got !== exp)
      begin
         $display("Error at %0t ns: %s is %h, expected %h", $time, name, got, exp);
         errors++;
      end
   endtask

   task automatic check_word(input string name, input ram_ctrl_pkg::word_t got,
                             input ram_ctrl_pkg::word_t exp);
      if (got !== exp)
      begin
         $display("Error at %0t ns: %s is %h, expected %h", $time, name, got, exp);
         errors++;
      end
   endtask

   task automatic check_addr(input string name, input ram_ctrl_pkg::sram_addr_t got,
                             input ram_ctrl_pkg::sram_addr_t exp);
      if (got !== exp)
      begin
         $display("Error at %0t ns: %s is %h, expected %h", $time, name, got, exp);
         errors++;
      end
   endtask

   task automatic check_flag(input string name, input logic got, input logic exp);
      if (got !== exp)
      begin
         $display("Error at %0t ns: %s is %b, expected %b", $time, name, got, exp);
         errors++;
      end
   endtask

   // --------------------
   // request handling
   // --------------------
   function automatic logic flag_of(input int kind);
      case (kind)
         ram_ctrl_pkg::PRI_MCR_RD:   return mcr_ready;
         ram_ctrl_pkg::PRI_MCR_WR:   return mcr_done;
         ram_ctrl_pkg::PRI_VGA_RD:   return vga_ready;
         ram_ctrl_pkg::PRI_SDRAM_RD: return sdram_ready;
         default:                    return sdram_done;
      endcase
   endfunction

   function automatic string flag_name(input int kind);
      case (kind)
         ram_ctrl_pkg::PRI_MCR_RD:   return "mcr_ready";
         ram_ctrl_pkg::PRI_MCR_WR:   return "mcr_done";
         ram_ctrl_pkg::PRI_VGA_RD:   return "vga_ready";
         ram_ctrl_pkg::PRI_SDRAM_RD: return "sdram_ready";
         default:                    return "sdram_done";
      endcase
   endfunction

   task automatic set_level(input int kind, input logic level);
      case (kind)
         ram_ctrl_pkg::PRI_MCR_RD:   mcr_read = level;
         ram_ctrl_pkg::PRI_MCR_WR:   mcr_write = level;
         ram_ctrl_pkg::PRI_VGA_RD:   vga_read = level;
         ram_ctrl_pkg::PRI_SDRAM_RD: sdram_read = level;
         default:                    sdram_write = level;
      endcase
   endtask

   // flags are sampled on the falling edge, away from the update
   task automatic wait_flag(input int kind, input logic level);
      int n;
      n = 0;
      if (!timed_out)
      begin
         @(negedge clk);
         while (flag_of(kind) !== level && n < TIMEOUT_CYCLES)
         begin
            @(negedge clk);
            n++;
         end
         if (flag_of(kind) !== level)
         begin
            $display("timeout: %s did not reach %b within %0d cycles",
                     flag_name(kind), level, TIMEOUT_CYCLES);
            timed_out = 1'b1;
         end
      end
   endtask

   task automatic step_to_drive();
      @(posedge clk);
      #2;
   endtask

   task automatic raise_request(input int kind);
      set_level(kind, 1'b1);
      wait_flag(kind, 1'b1);
   endtask

   // the flag must still be up while the level is held
   task automatic drop_request(input int kind);
      step_to_drive();
      check_flag(flag_name(kind), flag_of(kind), 1'b1);
      set_level(kind, 1'b0);
      wait_flag(kind, 1'b0);
   endtask

   task automatic write_mcr(input ram_ctrl_pkg::mcr_addr_t a, input ram_ctrl_pkg::mcr_word_t d);
      step_to_drive();
      mcr_addr  = a;
      mcr_wdata = d;
      raise_request(ram_ctrl_pkg::PRI_MCR_WR);
      shadow[int'({3'b100, a, 1'b0})] = {15'b0, d[48:32]};
      shadow[int'({3'b100, a, 1'b1})] = d[31:0];
      drop_request(ram_ctrl_pkg::PRI_MCR_WR);
   endtask

   task automatic read_mcr(input ram_ctrl_pkg::mcr_addr_t a);
      step_to_drive();
      mcr_addr = a;
      raise_request(ram_ctrl_pkg::PRI_MCR_RD);
      check_mcr("mcr_rdata", mcr_rdata, mcr_expected(a));
      drop_request(ram_ctrl_pkg::PRI_MCR_RD);
   endtask

   task automatic write_sdram(input ram_ctrl_pkg::sdram_addr_t a, input ram_ctrl_pkg::word_t d);
      step_to_drive();
      sdram_addr  = a;
      sdram_wdata = d;
      raise_request(ram_ctrl_pkg::PRI_SDRAM_WR);
      shadow[int'({1'b0, a[16:0]})] = d;
      drop_request(ram_ctrl_pkg::PRI_SDRAM_WR);
   endtask

   task automatic read_sdram(input ram_ctrl_pkg::sdram_addr_t a);
      step_to_drive();
      sdram_addr = a;
      raise_request(ram_ctrl_pkg::PRI_SDRAM_RD);
      check_word("sdram_rdata", sdram_rdata, sdram_expected(a));
      drop_request(ram_ctrl_pkg::PRI_SDRAM_RD);
   endtask

   // pins keep the last address until the next access starts
   task automatic read_vga(input ram_ctrl_pkg::vga_addr_t a);
      step_to_drive();
      vga_addr = a;
      raise_request(ram_ctrl_pkg::PRI_VGA_RD);
      check_word("vga_rdata", vga_rdata, shadow_word({3'b110, a}));
      check_addr("sram_a", sram_a, {3'b110, a});
      drop_request(ram_ctrl_pkg::PRI_VGA_RD);
   endtask

   task automatic finish_test(input string name, input int mark);
      tests++;
      if (errors == mark && !timed_out)
         $display("test %0d %s: ok", tests, name);
      else
         $display("test %0d %s: FAILED", tests, name);
   endtask

   // --------------------
   // test sequence
   // --------------------
   initial
   begin
      logic [31:0]               r1;
      logic [31:0]               r2;
      ram_ctrl_pkg::sdram_addr_t sa;
      int                        mark;
      int                        n;

      rng         = 32'd8;
      errors      = 0;
      tests       = 0;
      timed_out   = 1'b0;
      clk         = 1'b0;
      reset       = 1'b1;
      mcr_read    = 1'b0;
      mcr_write   = 1'b0;
      mcr_addr    = '0;
      mcr_wdata   = '0;
      sdram_read  = 1'b0;
      sdram_write = 1'b0;
      sdram_addr  = '0;
      sdram_wdata = '0;
      vga_read    = 1'b0;
      vga_addr    = '0;
      repeat (2) @(posedge clk);
      #2;
      reset = 1'b0;

      mark = errors;
      @(negedge clk);
      check_flag("mcr_ready", mcr_ready, 1'b0);
      check_flag("mcr_done", mcr_done, 1'b0);
      check_flag("sdram_ready", sdram_ready, 1'b0);
      check_flag("sdram_done", sdram_done, 1'b0);
      check_flag("vga_ready", vga_ready, 1'b0);
      check_mcr("mcr_rdata", mcr_rdata, '0);
      check_word("sdram_rdata", sdram_rdata, '0);
      check_word("vga_rdata", vga_rdata, '0);
      check_flag("sram_oe_n", sram_oe_n, 1'b1);
      check_flag("sram_we_n", sram_we_n, 1'b1);
      check_flag("sram_ce_n", sram_ce_n, 1'b1);
      finish_test("reset state", mark);

      mark = errors;
      for (int i = 0; i < NUM_WORDS; i++)
      begin
         r1 = next_random();
         r2 = next_random();
         write_mcr(r1[13:0], {r1[30:14], r2});
         mcr_used.push_back(r1[13:0]);
      end
      foreach (mcr_used[i])
         read_mcr(mcr_used[i]);
      finish_test("microcode write and read", mark);

      mark = errors;
      for (int i = 0; i < NUM_WORDS; i++)
      begin
         r1 = next_random();
         r2 = next_random();
         sa = {5'b0, r1[16:0]};
         write_sdram(sa, r2);
         sdram_used.push_back(sa);
      end
      foreach (sdram_used[i])
         read_sdram(sdram_used[i]);
      // outside the window, at least one of bits 21..17 set
      for (int i = 0; i < NUM_WORDS / 2; i++)
      begin
         r1 = next_random();
         sa = {r1[21:17] | 5'b00001 << (i % 5), r1[16:0]};
         read_sdram(sa);
      end
      finish_test("main memory window", mark);

      mark = errors;
      for (int i = 0; i < NUM_WORDS; i++)
      begin
         r1 = next_random();
         read_vga(r1[14:0]);
      end
      finish_test("video partition", mark);

      // three requesters on the same cycle
      mark = errors;
      r1 = next_random();
      step_to_drive();
      mcr_addr   = mcr_used[0];
      vga_addr   = r1[14:0];
      sdram_addr = sdram_used[1];
      mcr_read   = 1'b1;
      vga_read   = 1'b1;
      sdram_read = 1'b1;
      n = 0;
      @(negedge clk);
      while (!(mcr_ready || vga_ready || sdram_ready) && n < TIMEOUT_CYCLES)
      begin
         @(negedge clk);
         n++;
      end
      if (!(mcr_ready || vga_ready || sdram_ready))
      begin
         $display("timeout: no flag rose after three simultaneous requests");
         timed_out = 1'b1;
      end
      check_flag("mcr_ready", mcr_ready, 1'b1);
      check_flag("vga_ready", vga_ready, 1'b0);
      check_flag("sdram_ready", sdram_ready, 1'b0);
      wait_flag(ram_ctrl_pkg::PRI_VGA_RD, 1'b1);
      wait_flag(ram_ctrl_pkg::PRI_SDRAM_RD, 1'b1);
      check_mcr("mcr_rdata", mcr_rdata, mcr_expected(mcr_used[0]));
      check_word("vga_rdata", vga_rdata, shadow_word({3'b110, r1[14:0]}));
      check_word("sdram_rdata", sdram_rdata, sdram_expected(sdram_used[1]));
      step_to_drive();
      mcr_read   = 1'b0;
      vga_read   = 1'b0;
      sdram_read = 1'b0;
      wait_flag(ram_ctrl_pkg::PRI_MCR_RD, 1'b0);
      wait_flag(ram_ctrl_pkg::PRI_VGA_RD, 1'b0);
      wait_flag(ram_ctrl_pkg::PRI_SDRAM_RD, 1'b0);
      finish_test("simultaneous requests", mark);

      // same kind again once the flag is low
      mark = errors;
      read_sdram(sdram_used[2]);
      read_sdram(sdram_used[2]);
      r1 = next_random();
      r2 = next_random();
      write_mcr(mcr_used[1], {r1[16:0], r2});
      write_mcr(mcr_used[1], {r2[16:0], r1});
      read_mcr(mcr_used[1]);
      finish_test("repeated requests", mark);

      $display("%0d tests run, %0d errors", tests, errors);
      if (errors == 0 && !timed_out)
         $display("All tests passed");
      else
         $display("Some tests failed");
      $finish;
   end

endmodule

//--- filelist.f
design/ram_ctrl_pkg.sv
design/port_arbiter.sv
design/sram_cycle.sv
design/port_response.sv
design/pipe_ram_controller.sv
verif/sram_model.sv
verif/tb_pipe_ram_controller.sv

//--- run_sim.sh
#!/bin/sh
# build the testbench with Verilator, run it, and look for the pass line in the log

cd "$(dirname "$0")" || exit 1

log=sim.log
rm -f "$log"

verilator --binary --timing -j 0 --top-module tb_pipe_ram_controller \
   -f filelist.f -o tb_sim
if [ $? -ne 0 ]; then
   echo "build failed"
   exit 1
fi

./obj_dir/tb_sim > "$log" 2>&1
status=$?
cat "$log"
if [ $status -ne 0 ]; then
   echo "simulation exited with status $status"
   exit 1
fi

if grep -q "^All tests passed$" "$log"; then
   exit 0
fi
echo "pass line not found in $log"
exit 1
